//--- boot_pkg.sv
// ----------------------------------------------------------------------
// Boot platform shared definitions
// ----------------------------------------------------------------------

package boot_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // ----------------------------------------------------------------------
  // Internal CSR bus offsets
  // ----------------------------------------------------------------------
  typedef logic [7:0] csr_addr_t;

  localparam csr_addr_t CSR_MODEFLAGS  = 8'h00;
  localparam csr_addr_t CSR_ACCEL_CTRL = 8'h04;
  localparam csr_addr_t CSR_ACCEL_MODE = 8'h08;
  localparam csr_addr_t CSR_COMP_BASE  = 8'h0C;

  // ----------------------------------------------------------------------
  // Host MMIO offsets
  // ----------------------------------------------------------------------
  typedef logic [7:0] mmio_addr_t;

  localparam mmio_addr_t MMIO_SIGNATURE = 8'h00;
  localparam mmio_addr_t MMIO_POWEROFF  = 8'h04;
  localparam mmio_addr_t MMIO_STATUS    = 8'h08;
  localparam mmio_addr_t MMIO_COMP_BASE = 8'h0C;

  // ----------------------------------------------------------------------
  // Enums
  // ----------------------------------------------------------------------
  // Accelerator operating mode, as held in the mode register
  typedef enum logic [7:0] {
    ACCEL_MODE_NATIVE = 8'h00,
    ACCEL_MODE_AM9511 = 8'h01,
    ACCEL_MODE_AM9513 = 8'h02
  } accel_mode_e;

  // Boot sequencer steps, one per configuration write
  typedef enum logic [2:0] {
    STEP_MODEFLAGS,
    STEP_ACCEL_CTRL,
    STEP_ACCEL_MODE,
    STEP_COMP_BASE,
    STEP_DONE
  } init_step_e;

  // ----------------------------------------------------------------------
  // Boot values and reset values
  // ----------------------------------------------------------------------
  // Native-mode bit only
  localparam logic [7:0]        DEFAULT_MODE_FLAGS = 8'h04;
  localparam logic [DATA_W-1:0] DEFAULT_COMP_BASE  = 32'h0000_0500;
  localparam logic [DATA_W-1:0] ACCEL_CTRL_ENABLE  = 32'h0000_0001;

  localparam logic [7:0]        MODE_FLAGS_RESET = 8'h00;
  localparam logic [DATA_W-1:0] COMP_BASE_RESET  = 32'h0000_0000;
  localparam logic [DATA_W-1:0] SIGNATURE_RESET  = 32'h0000_0000;

endpackage : boot_pkg

//--- csr_apb_master.sv
// ----------------------------------------------------------------------
// Single-write APB master for the CSR bus
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module csr_apb_master (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  boot_pkg::csr_addr_t         addr,
  input  logic [boot_pkg::DATA_W-1:0] wdata,
  input  logic                        csr_pready,
  output logic                        busy,
  output logic                        done,
  output logic                        csr_psel,
  output logic                        csr_penable,
  output boot_pkg::csr_addr_t         csr_paddr,
  output logic [boot_pkg::DATA_W-1:0] csr_pwdata
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_ACCESS
  } phase_e;

  phase_e                        phase_q;
  logic                          done_q;
  boot_pkg::csr_addr_t           addr_q;
  logic [boot_pkg::DATA_W-1:0]   wdata_q;

  // Phase machine, one write per accepted start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (phase_q)
        PH_IDLE: begin
          if (start) phase_q <= PH_SETUP;
        end
        PH_SETUP: begin
          phase_q <= PH_ACCESS;
        end
        PH_ACCESS: begin
          // Target may stretch the access phase
          if (csr_pready) begin
            phase_q <= PH_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: begin
          phase_q <= PH_IDLE;
        end
      endcase
    end
  end

  // Request captured with start
  always_ff @(posedge clk) begin
    if (start && (phase_q == PH_IDLE)) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // Busy covers the done cycle as well
  assign busy        = (phase_q != PH_IDLE) || done_q;
  assign done        = done_q;
  assign csr_psel    = (phase_q != PH_IDLE);
  assign csr_penable = (phase_q == PH_ACCESS);
  assign csr_paddr   = addr_q;
  assign csr_pwdata  = wdata_q;

endmodule : csr_apb_master

//--- boot_init_seq.sv
// ----------------------------------------------------------------------
// Boot configuration sequencer and CPU release
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module boot_init_seq #(
  parameter logic [7:0]            MODE_FLAGS = boot_pkg::DEFAULT_MODE_FLAGS,
  parameter boot_pkg::accel_mode_e ACCEL_MODE = boot_pkg::ACCEL_MODE_AM9513
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        busy,
  input  logic                        done,
  output logic                        start,
  output boot_pkg::csr_addr_t         addr,
  output logic [boot_pkg::DATA_W-1:0] wdata,
  output logic                        cpu_halt,
  output logic                        cpu_run
);

  boot_pkg::init_step_e step_q;
  boot_pkg::init_step_e step_next;
  logic                 issued_q;

  // ----------------------------------------------------------------------
  // Per-step register offset and value
  // ----------------------------------------------------------------------
  always_comb begin
    addr  = '0;
    wdata = '0;
    case (step_q)
      boot_pkg::STEP_MODEFLAGS: begin
        addr  = boot_pkg::CSR_MODEFLAGS;
        wdata = {24'h00_0000, MODE_FLAGS};
      end
      boot_pkg::STEP_ACCEL_CTRL: begin
        addr  = boot_pkg::CSR_ACCEL_CTRL;
        wdata = boot_pkg::ACCEL_CTRL_ENABLE;
      end
      boot_pkg::STEP_ACCEL_MODE: begin
        addr  = boot_pkg::CSR_ACCEL_MODE;
        wdata = {24'h00_0000, ACCEL_MODE};
      end
      boot_pkg::STEP_COMP_BASE: begin
        addr  = boot_pkg::CSR_COMP_BASE;
        wdata = boot_pkg::DEFAULT_COMP_BASE;
      end
      default: begin
      end
    endcase
  end

  // Steps are numbered in write order
  assign step_next = boot_pkg::init_step_e'(step_q + 3'd1);

  // ----------------------------------------------------------------------
  // Step control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q   <= boot_pkg::STEP_MODEFLAGS;
      issued_q <= 1'b0;
      start    <= 1'b0;
      cpu_halt <= 1'b1;
      cpu_run  <= 1'b0;
    end else begin
      start   <= 1'b0;
      cpu_run <= 1'b0;
      if (done) begin
        step_q <= step_next;
        if (step_q == boot_pkg::STEP_COMP_BASE) begin
          issued_q <= 1'b0;
          // Halt never comes back, so this fires once
          if (cpu_halt) begin
            cpu_halt <= 1'b0;
            cpu_run  <= 1'b1;
          end
        end else begin
          // Next write goes out right behind the done
          start    <= 1'b1;
          issued_q <= 1'b1;
        end
      end else if ((step_q != boot_pkg::STEP_DONE) && !issued_q && !busy) begin
        start    <= 1'b1;
        issued_q <= 1'b1;
      end
    end
  end

endmodule : boot_init_seq

//--- platform_csr_regs.sv
// ----------------------------------------------------------------------
// Platform configuration registers
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module platform_csr_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        csr_psel,
  input  logic                        csr_penable,
  input  boot_pkg::csr_addr_t         csr_paddr,
  input  logic [boot_pkg::DATA_W-1:0] csr_pwdata,
  output logic                        csr_pready,
  output logic [7:0]                  mode_flags,
  output logic                        accel_enable,
  output boot_pkg::accel_mode_e       accel_mode,
  output logic [boot_pkg::DATA_W-1:0] comp_base
);

  logic wr_en;

  // Zero wait states
  assign csr_pready = 1'b1;

  // Write completes in the access phase
  assign wr_en = csr_psel && csr_penable && csr_pready;

  // ----------------------------------------------------------------------
  // Register file
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_flags   <= boot_pkg::MODE_FLAGS_RESET;
      accel_enable <= 1'b0;
      accel_mode   <= boot_pkg::ACCEL_MODE_NATIVE;
      comp_base    <= boot_pkg::COMP_BASE_RESET;
    end else if (wr_en) begin
      case (csr_paddr)
        boot_pkg::CSR_MODEFLAGS: begin
          mode_flags <= csr_pwdata[7:0];
        end
        boot_pkg::CSR_ACCEL_CTRL: begin
          // Enable lives in bit 0
          accel_enable <= csr_pwdata[0];
        end
        boot_pkg::CSR_ACCEL_MODE: begin
          accel_mode <= boot_pkg::accel_mode_e'(csr_pwdata[7:0]);
        end
        boot_pkg::CSR_COMP_BASE: begin
          comp_base <= csr_pwdata;
        end
        default: begin
          // Unknown offsets dropped
        end
      endcase
    end
  end

endmodule : platform_csr_regs

//--- mmio_regs.sv
// ----------------------------------------------------------------------
// Host MMIO register block
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module mmio_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  boot_pkg::mmio_addr_t        paddr,
  input  logic [boot_pkg::DATA_W-1:0] pwdata,
  input  logic                        cpu_halt,
  input  logic [7:0]                  mode_flags,
  input  logic                        accel_enable,
  input  boot_pkg::accel_mode_e       accel_mode,
  input  logic [boot_pkg::DATA_W-1:0] comp_base,
  output logic [boot_pkg::DATA_W-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr,
  output logic [boot_pkg::DATA_W-1:0] signature,
  output logic                        poweroff
);

  logic                        access;
  logic                        bad_req;
  logic                        wr_en;
  logic [boot_pkg::DATA_W-1:0] status_word;
  logic [boot_pkg::DATA_W-1:0] rd_mux;

  assign pready = 1'b1;
  assign access = psel && penable;

  // Flags, mode and enable packed low, rest zero
  always_comb begin
    status_word        = '0;
    status_word[7:0]   = mode_flags;
    status_word[15:8]  = accel_mode;
    status_word[16]    = accel_enable;
  end

  // ----------------------------------------------------------------------
  // Decode and read mux
  // ----------------------------------------------------------------------
  always_comb begin
    bad_req = 1'b0;
    rd_mux  = '0;
    case (paddr)
      boot_pkg::MMIO_SIGNATURE: rd_mux = signature;
      boot_pkg::MMIO_POWEROFF:  rd_mux = {{(boot_pkg::DATA_W-1){1'b0}}, poweroff};
      boot_pkg::MMIO_STATUS: begin
        rd_mux  = status_word;
        bad_req = pwrite;
      end
      boot_pkg::MMIO_COMP_BASE: begin
        rd_mux  = comp_base;
        bad_req = pwrite;
      end
      default: bad_req = 1'b1;
    endcase
    // Port closed until the CPU is released
    if (cpu_halt) bad_req = 1'b1;
  end

  assign pslverr = access && bad_req;
  assign prdata  = (access && !pwrite && !bad_req) ? rd_mux : '0;
  assign wr_en   = access && pwrite && !bad_req;

  // ----------------------------------------------------------------------
  // Writable registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signature <= boot_pkg::SIGNATURE_RESET;
      poweroff  <= 1'b0;
    end else if (wr_en) begin
      if (paddr == boot_pkg::MMIO_SIGNATURE) signature <= pwdata;
      // Sticky until reset
      if ((paddr == boot_pkg::MMIO_POWEROFF) && pwdata[0]) poweroff <= 1'b1;
    end
  end

endmodule : mmio_regs

//--- carbon_boot_top.sv
// ----------------------------------------------------------------------
// Boot platform top level
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module carbon_boot_top #(
  parameter logic [7:0]            MODE_FLAGS = boot_pkg::DEFAULT_MODE_FLAGS,
  parameter boot_pkg::accel_mode_e ACCEL_MODE = boot_pkg::ACCEL_MODE_AM9513
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Host APB port
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [boot_pkg::ADDR_W-1:0] paddr,
  input  logic [boot_pkg::DATA_W-1:0] pwdata,
  output logic [boot_pkg::DATA_W-1:0] prdata,
  output logic                        pready,
  output logic                        pslverr,
  // CPU control and status
  output logic                        cpu_halt,
  output logic                        cpu_run,
  output logic [boot_pkg::DATA_W-1:0] signature,
  output logic                        poweroff
);

  // Sequencer to master
  logic                        start;
  logic                        busy;
  logic                        done;
  boot_pkg::csr_addr_t         seq_addr;
  logic [boot_pkg::DATA_W-1:0] seq_wdata;

  // Internal CSR bus
  logic                        csr_psel;
  logic                        csr_penable;
  boot_pkg::csr_addr_t         csr_paddr;
  logic [boot_pkg::DATA_W-1:0] csr_pwdata;
  logic                        csr_pready;

  // Configuration seen by the MMIO block
  logic [7:0]                  mode_flags;
  logic                        accel_enable;
  boot_pkg::accel_mode_e       accel_mode;
  logic [boot_pkg::DATA_W-1:0] comp_base;

  boot_init_seq #(
    .MODE_FLAGS(MODE_FLAGS),
    .ACCEL_MODE(ACCEL_MODE)
  ) u_init_seq (
    .clk(clk),
    .rst_n(rst_n),
    .busy(busy),
    .done(done),
    .start(start),
    .addr(seq_addr),
    .wdata(seq_wdata),
    .cpu_halt(cpu_halt),
    .cpu_run(cpu_run)
  );

  csr_apb_master u_csr_master (
    .clk(clk),
    .rst_n(rst_n),
    .start(start),
    .addr(seq_addr),
    .wdata(seq_wdata),
    .csr_pready(csr_pready),
    .busy(busy),
    .done(done),
    .csr_psel(csr_psel),
    .csr_penable(csr_penable),
    .csr_paddr(csr_paddr),
    .csr_pwdata(csr_pwdata)
  );

  platform_csr_regs u_csr_regs (
    .clk(clk),
    .rst_n(rst_n),
    .csr_psel(csr_psel),
    .csr_penable(csr_penable),
    .csr_paddr(csr_paddr),
    .csr_pwdata(csr_pwdata),
    .csr_pready(csr_pready),
    .mode_flags(mode_flags),
    .accel_enable(accel_enable),
    .accel_mode(accel_mode),
    .comp_base(comp_base)
  );

  // Only the low offset bits select a register
  mmio_regs u_mmio (
    .clk(clk),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr[$bits(boot_pkg::mmio_addr_t)-1:0]),
    .pwdata(pwdata),
    .cpu_halt(cpu_halt),
    .mode_flags(mode_flags),
    .accel_enable(accel_enable),
    .accel_mode(accel_mode),
    .comp_base(comp_base),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .signature(signature),
    .poweroff(poweroff)
  );

endmodule : carbon_boot_top

//--- tb_carbon_boot_chk.sv
// ----------------------------------------------------------------------
// Boot platform release and error checker
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module carbon_boot_chk (
  input logic clk,
  input logic rst_n,
  input logic cpu_halt,
  input logic cpu_run,
  input logic psel,
  input logic penable,
  input logic pslverr
);

  int fail_count = 0;

  // Run is a single-cycle pulse
  run_pulse_single: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_run |=> !cpu_run)
    else begin
      $error("cpu_run high on two consecutive cycles");
      fail_count++;
    end

  // Halt is released once and never comes back
  halt_stays_released: assert property (@(posedge clk) disable iff (!rst_n)
    !cpu_halt |=> !cpu_halt)
    else begin
      $error("cpu_halt rose again after release");
      fail_count++;
    end

  // Host port refuses everything while halted
  halted_access_error: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && cpu_halt) |-> pslverr)
    else begin
      $error("access cycle during halt without pslverr");
      fail_count++;
    end

endmodule : carbon_boot_chk

bind carbon_boot_top carbon_boot_chk u_chk (
  .clk(clk),
  .rst_n(rst_n),
  .cpu_halt(cpu_halt),
  .cpu_run(cpu_run),
  .psel(psel),
  .penable(penable),
  .pslverr(pslverr)
);

//--- tb_carbon_boot.sv
// ----------------------------------------------------------------------
// Boot platform directed testbench
// ----------------------------------------------------------------------
`timescale 1ns/10ps

module tb_carbon_boot;

  localparam int CLK_PERIOD_NS = 100;
  localparam int NUM_TESTS     = 6;
  localparam int TEST_CYCLES   = 200;
  localparam int RELEASE_LIMIT = 200;
  // Flags 0x04 in 7:0, AM9513 (0x02) in 15:8, enable in bit 16
  localparam logic [boot_pkg::DATA_W-1:0] EXP_STATUS    = 32'h0001_0204;
  localparam logic [boot_pkg::DATA_W-1:0] EXP_COMP_BASE = 32'h0000_0500;

  logic                        clk;
  logic                        rst_n;
  logic                        psel;
  logic                        penable;
  logic                        pwrite;
  logic [boot_pkg::ADDR_W-1:0] paddr;
  logic [boot_pkg::DATA_W-1:0] pwdata;
  logic [boot_pkg::DATA_W-1:0] prdata;
  logic                        pready;
  logic                        pslverr;
  logic                        cpu_halt;
  logic                        cpu_run;
  logic [boot_pkg::DATA_W-1:0] signature;
  logic                        poweroff;

  int                          error_count = 0;
  int                          check_count = 0;
  int                          test_count = 0;
  int                          last_error_count = 0;
  int                          run_high_cycles = 0;
  logic [31:0]                 lfsr_state = 32'ha3f3_f091;
  logic [boot_pkg::DATA_W-1:0] expected_signature = '0;

  carbon_boot_top UUT (
    .clk(clk),
    .rst_n(rst_n),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .cpu_halt(cpu_halt),
    .cpu_run(cpu_run),
    .signature(signature),
    .poweroff(poweroff)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  // Watchdog sized from the per-test cycle budget
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  always @(negedge clk) begin
    if (rst_n && cpu_run) run_high_cycles++;
  end

  // ----------------------------------------------------------------------
  // Random values and compare tasks
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic random_word(output logic [boot_pkg::DATA_W-1:0] w);
    w = '0;
    for (int b = 0; b < boot_pkg::DATA_W; b++) begin
      w = {w[boot_pkg::DATA_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic compare_word(input string name, input logic [boot_pkg::DATA_W-1:0] got,
                              input logic [boot_pkg::DATA_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic compare_mode(input string name, input boot_pkg::accel_mode_e got,
                              input boot_pkg::accel_mode_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    if (error_count == last_error_count) $display("test %0d %s: ok", test_count, name);
    else $display("test %0d %s: %0d errors", test_count, name, error_count - last_error_count);
    last_error_count = error_count;
  endtask

  // ----------------------------------------------------------------------
  // Host APB transfers, sampled mid access cycle
  // ----------------------------------------------------------------------
  task automatic apb_write(input boot_pkg::mmio_addr_t addr,
                           input logic [boot_pkg::DATA_W-1:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= {{(boot_pkg::ADDR_W-8){1'b0}}, addr};
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    err = pslverr;
    compare_bit("pready", pready, 1'b1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    @(negedge clk);
  endtask

  task automatic apb_read(input boot_pkg::mmio_addr_t addr,
                          output logic [boot_pkg::DATA_W-1:0] data, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= {{(boot_pkg::ADDR_W-8){1'b0}}, addr};
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    compare_bit("pready", pready, 1'b1);
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(negedge clk);
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic halted_refusal;
    logic err;
    compare_bit("cpu_halt", cpu_halt, 1'b1);
    compare_bit("cpu_run", cpu_run, 1'b0);
    apb_write(boot_pkg::MMIO_SIGNATURE, 32'h5A5A_1234, err);
    compare_bit("pslverr", err, 1'b1);
    compare_word("signature", signature, 32'h0000_0000);
    report_test("halted access refused");
  endtask

  task automatic cpu_release;
    int waited;
    waited = 0;
    while (cpu_halt && (waited < RELEASE_LIMIT)) begin
      @(negedge clk);
      waited++;
    end
    if (cpu_halt) begin
      error_count++;
      $display("cpu_halt did not fall within %0d cycles", RELEASE_LIMIT);
    end else begin
      // Give the pulse time to end
      repeat (3) @(negedge clk);
      check_count++;
      if (run_high_cycles != 1) begin
        error_count++;
        $display("cpu_run was high for %0d cycles instead of one", run_high_cycles);
      end
    end
    report_test("release");
  endtask

  task automatic config_readback;
    logic [boot_pkg::DATA_W-1:0] rd;
    logic                        err;
    apb_read(boot_pkg::MMIO_STATUS, rd, err);
    compare_bit("pslverr", err, 1'b0);
    compare_word("status", rd, EXP_STATUS);
    compare_mode("status accel_mode", boot_pkg::accel_mode_e'(rd[15:8]),
                 boot_pkg::ACCEL_MODE_AM9513);
    compare_bit("status accel_enable", rd[16], 1'b1);
    apb_read(boot_pkg::MMIO_COMP_BASE, rd, err);
    compare_bit("pslverr", err, 1'b0);
    compare_word("comp_base", rd, EXP_COMP_BASE);
    report_test("configuration applied");
  endtask

  task automatic signature_rw;
    logic [boot_pkg::DATA_W-1:0] value;
    logic [boot_pkg::DATA_W-1:0] rd;
    logic                        err;
    for (int i = 0; i < 8; i++) begin
      random_word(value);
      apb_write(boot_pkg::MMIO_SIGNATURE, value, err);
      compare_bit("pslverr", err, 1'b0);
      compare_word("signature", signature, value);
      apb_read(boot_pkg::MMIO_SIGNATURE, rd, err);
      compare_bit("pslverr", err, 1'b0);
      compare_word("prdata", rd, value);
      expected_signature = value;
    end
    report_test("signature register");
  endtask

  task automatic error_responses;
    logic [boot_pkg::DATA_W-1:0] rd;
    logic                        err;
    apb_read(8'h10, rd, err);
    compare_bit("pslverr unmapped read", err, 1'b1);
    apb_write(boot_pkg::MMIO_STATUS, 32'hFFFF_FFFF, err);
    compare_bit("pslverr status write", err, 1'b1);
    apb_write(boot_pkg::MMIO_COMP_BASE, 32'hDEAD_BEEF, err);
    compare_bit("pslverr comp_base write", err, 1'b1);
    apb_read(boot_pkg::MMIO_STATUS, rd, err);
    compare_word("status", rd, EXP_STATUS);
    apb_read(boot_pkg::MMIO_COMP_BASE, rd, err);
    compare_word("comp_base", rd, EXP_COMP_BASE);
    compare_word("signature", signature, expected_signature);
    compare_bit("poweroff", poweroff, 1'b0);
    report_test("errors after release");
  endtask

  task automatic poweroff_sticky;
    logic [boot_pkg::DATA_W-1:0] rd;
    logic                        err;
    apb_write(boot_pkg::MMIO_POWEROFF, 32'h0000_0000, err);
    compare_bit("pslverr", err, 1'b0);
    compare_bit("poweroff", poweroff, 1'b0);
    apb_write(boot_pkg::MMIO_POWEROFF, 32'h0000_0001, err);
    compare_bit("poweroff", poweroff, 1'b1);
    apb_write(boot_pkg::MMIO_POWEROFF, 32'h0000_0000, err);
    compare_bit("poweroff", poweroff, 1'b1);
    apb_read(boot_pkg::MMIO_POWEROFF, rd, err);
    compare_bit("pslverr", err, 1'b0);
    compare_word("prdata", rd, 32'h0000_0001);
    report_test("power-off");
  endtask

  initial begin
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    halted_refusal();
    cpu_release();
    config_readback();
    signature_rw();
    error_responses();
    poweroff_sticky();

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, check_count, error_count, UUT.u_chk.fail_count);
    if ((error_count == 0) && (UUT.u_chk.fail_count == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_carbon_boot

//--- carbon_boot.f
boot_pkg.sv
csr_apb_master.sv
boot_init_seq.sv
platform_csr_regs.sv
mmio_regs.sv
carbon_boot_top.sv
tb_carbon_boot_chk.sv
tb_carbon_boot.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the boot platform testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_carbon_boot \
  -f carbon_boot.f -o sim_carbon_boot
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_carbon_boot > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
exit 1
